//--- build.f
hw/lsu_pkg.sv
hw/lsu_decode.sv
hw/lsu_execute.sv
hw/lsu_result.sv
hw/lsu_top.sv
test/apb_mem_model.sv
test/lsu_tb.sv

//--- Bender.yml
package:
  name: lsu

sources:
  - hw/lsu_pkg.sv
  - hw/lsu_decode.sv
  - hw/lsu_execute.sv
  - hw/lsu_result.sv
  - hw/lsu_top.sv
  - target: test
    files:
      - test/apb_mem_model.sv
      - test/lsu_tb.sv

//--- test/lsu_tb.sv
`default_nettype none

module lsu_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int ADDR_WIDTH      = 10;
	localparam int DW              = lsu_pkg::DATA_WIDTH;
	localparam int RW              = lsu_pkg::REG_ADDR_WIDTH;
	localparam int WORDS           = 2 ** (ADDR_WIDTH - 2);
	localparam int CYCLES_PER_INST = 40;
	localparam int CYCLE_SLACK     = 200;
	localparam int RANDOM_OPS      = 200;

	logic                  clk;
	logic                  reset;
	logic                  flush;
	logic                  valid;
	logic                  ready;
	logic [31:0]           inst;
	logic [DW-1:0]         base;
	logic [DW-1:0]         store_data;
	logic                  psel;
	logic                  penable;
	logic                  pwrite;
	logic [ADDR_WIDTH-1:0] paddr;
	logic [DW-1:0]         pwdata;
	logic [3:0]            pstrb;
	logic [DW-1:0]         prdata;
	logic                  pready;
	logic                  pslverr;
	logic                  wb_valid;
	logic [RW-1:0]         wb_waddr;
	logic [DW-1:0]         wb_wdata;
	logic [3:0]            wb_wren;
	logic                  err;
	int                    xfer_count;

	// shadow copy of the data memory and the expected result queue
	logic [31:0]   shadow [WORDS];
	string         exp_name_q[$];
	bit            exp_err_q[$];
	logic [RW-1:0] exp_waddr_q[$];
	logic [31:0]   exp_wdata_q[$];
	logic [3:0]    exp_wren_q[$];

	// bus transfer expected for the instruction issued last
	logic [ADDR_WIDTH-1:0] apb_addr;
	logic                  apb_write;
	logic [31:0]           apb_mask;
	logic [31:0]           apb_wdata;
	logic [3:0]            apb_strb;

	int error_count;
	int check_count;
	int issued;
	int cycles;
	int test_err_start;

	lsu_top #(
		.ADDR_WIDTH (ADDR_WIDTH)
	) lsu_top_i (
		.clk          (clk),
		.reset_i      (reset),
		.flush_i      (flush),
		.valid_i      (valid),
		.ready_o      (ready),
		.inst_i       (inst),
		.base_i       (base),
		.store_data_i (store_data),
		.psel_o       (psel),
		.penable_o    (penable),
		.pwrite_o     (pwrite),
		.paddr_o      (paddr),
		.pwdata_o     (pwdata),
		.pstrb_o      (pstrb),
		.prdata_i     (prdata),
		.pready_i     (pready),
		.pslverr_i    (pslverr),
		.wb_valid_o   (wb_valid),
		.wb_waddr_o   (wb_waddr),
		.wb_wdata_o   (wb_wdata),
		.wb_wren_o    (wb_wren),
		.err_o        (err)
	);

	apb_mem_model #(
		.ADDR_WIDTH (ADDR_WIDTH)
	) mem_model_i (
		.clk          (clk),
		.reset_i      (reset),
		.psel_i       (psel),
		.penable_i    (penable),
		.pwrite_i     (pwrite),
		.paddr_i      (paddr),
		.pwdata_i     (pwdata),
		.pstrb_i      (pstrb),
		.prdata_o     (prdata),
		.pready_o     (pready),
		.pslverr_o    (pslverr),
		.xfer_count_o (xfer_count)
	);

	initial begin
		clk = 1'b0;
	end

	always #4 clk = ~clk;

	function automatic bit is_load(logic [5:0] opc);
		case (opc)
			lsu_pkg::OPC_LB, lsu_pkg::OPC_LBU, lsu_pkg::OPC_LH, lsu_pkg::OPC_LHU,
			lsu_pkg::OPC_LW, lsu_pkg::OPC_LWL, lsu_pkg::OPC_LWR: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	function automatic bit misaligned(logic [5:0] opc, logic [31:0] eff);
		case (opc)
			lsu_pkg::OPC_LH, lsu_pkg::OPC_LHU, lsu_pkg::OPC_SH: return eff[0];
			lsu_pkg::OPC_LW, lsu_pkg::OPC_SW: return |eff[1:0];
			default: return 1'b0;
		endcase
	endfunction

	// expected {byte enables, data} of a load taken from the memory word
	function automatic logic [35:0] load_ref(logic [5:0] opc, logic [31:0] word, logic [1:0] off);
		logic [7:0]  b;
		logic [15:0] h;
		logic [31:0] data;
		logic [3:0]  wren;
		b    = 8'(word >> (8 * off));
		h    = 16'(word >> (16 * off[1]));
		data = word;
		wren = 4'b1111;
		case (opc)
			lsu_pkg::OPC_LB: data = {{24{b[7]}}, b};
			lsu_pkg::OPC_LBU: data = {24'd0, b};
			lsu_pkg::OPC_LH: data = {{16{h[15]}}, h};
			lsu_pkg::OPC_LHU: data = {16'd0, h};
			lsu_pkg::OPC_LWL: begin
				data = word << (8 * (3 - off));
				wren = 4'b1111 << (3 - off);
			end
			lsu_pkg::OPC_LWR: begin
				data = word >> (8 * off);
				wren = 4'b1111 >> off;
			end
			default: data = word;
		endcase
		return {wren, data};
	endfunction

	// store lanes follow the low address bits
	function automatic logic [31:0] merge_store(logic [5:0] opc, logic [31:0] old,
		logic [31:0] data, logic [1:0] off);
		logic [31:0] merged;
		merged = old;
		case (opc)
			lsu_pkg::OPC_SB: merged[8*off +: 8] = data[7:0];
			lsu_pkg::OPC_SH: merged[16*off[1] +: 16] = data[15:0];
			default: merged = data;
		endcase
		return merged;
	endfunction

	function automatic logic [5:0] pick_opcode(int n);
		case (n)
			0: return lsu_pkg::OPC_LB;
			1: return lsu_pkg::OPC_LBU;
			2: return lsu_pkg::OPC_LH;
			3: return lsu_pkg::OPC_LHU;
			4: return lsu_pkg::OPC_LW;
			5: return lsu_pkg::OPC_LWL;
			6: return lsu_pkg::OPC_LWR;
			7: return lsu_pkg::OPC_SB;
			8: return lsu_pkg::OPC_SH;
			default: return lsu_pkg::OPC_SW;
		endcase
	endfunction

	task automatic check(string name, logic [31:0] exp, logic [31:0] act);
		check_count++;
		if (exp !== act) begin
			error_count++;
			$display("error %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic push_expect(string name, bit is_err, logic [RW-1:0] waddr,
		logic [31:0] wdata, logic [3:0] wren);
		exp_name_q.push_back(name);
		exp_err_q.push_back(is_err);
		exp_waddr_q.push_back(waddr);
		exp_wdata_q.push_back(wdata);
		exp_wren_q.push_back(wren);
	endtask

	// a squashed item leaves no expectation since the flush follows it
	task automatic issue(string name, logic [5:0] opc, logic [RW-1:0] rt, logic [31:0] b,
		logic [15:0] imm, logic [31:0] sdata, bit squash);
		logic [31:0]           eff;
		logic [ADDR_WIDTH-3:0] idx;
		logic [35:0]           res;
		eff = b + {{16{imm[15]}}, imm};
		idx = eff[ADDR_WIDTH-1:2];
		@(negedge clk);
		while (!ready) begin
			@(negedge clk);
		end
		valid      = 1'b1;
		inst       = {opc, 5'd3, rt, imm};
		base       = b;
		store_data = sdata;
		// lanes that a store of all ones would change
		apb_addr   = {eff[ADDR_WIDTH-1:2], 2'b00};
		apb_write  = !is_load(opc);
		apb_mask   = merge_store(opc, 32'd0, 32'hffffffff, eff[1:0]);
		if (is_load(opc)) begin
			apb_mask = 32'd0;
		end
		apb_wdata  = merge_store(opc, 32'd0, sdata, eff[1:0]) & apb_mask;
		for (int i = 0; i < 4; i++) begin
			apb_strb[i] = |apb_mask[8*i +: 8];
		end
		issued++;
		if (!squash) begin
			if (misaligned(opc, eff)) begin
				push_expect(name, 1'b1, '0, '0, '0);
			end else if (is_load(opc)) begin
				res = load_ref(opc, shadow[idx], eff[1:0]);
				push_expect(name, 1'b0, rt, res[31:0], res[35:32]);
			end else begin
				shadow[idx] = merge_store(opc, shadow[idx], sdata, eff[1:0]);
			end
		end
		@(negedge clk);
		valid = 1'b0;
	endtask

	task automatic drain();
		while (exp_name_q.size() != 0 || !ready) begin
			@(negedge clk);
		end
		// a few idle cycles catch any stray result
		repeat (4) @(negedge clk);
	endtask

	task automatic finish_test(string name);
		drain();
		$display("test %s finished: %0d mismatches", name, error_count - test_err_start);
		test_err_start = error_count;
	endtask

	// outputs are registered, so the falling edge sees them settled
	always @(negedge clk) begin : compare
		string name;
		bit    is_err;
		if (!reset && (wb_valid || err)) begin
			if (exp_name_q.size() == 0) begin
				error_count++;
				$display("unexpected %s at cycle %0d with no instruction outstanding",
					wb_valid ? "writeback" : "error pulse", cycles);
			end else begin
				name   = exp_name_q.pop_front();
				is_err = exp_err_q.pop_front();
				check({name, " err"}, 32'(is_err), 32'(err));
				check({name, " wb_valid"}, 32'(!is_err), 32'(wb_valid));
				if (!is_err) begin
					check({name, " waddr"}, 32'(exp_waddr_q[0]), 32'(wb_waddr));
					check({name, " wdata"}, exp_wdata_q[0], wb_wdata);
					check({name, " wren"}, 32'(exp_wren_q[0]), 32'(wb_wren));
				end
				void'(exp_waddr_q.pop_front());
				void'(exp_wdata_q.pop_front());
				void'(exp_wren_q.pop_front());
			end
		end
	end

	// every setup and access cycle carries the issued transfer unchanged
	always @(negedge clk) begin : apb_monitor
		if (!reset && (psel || penable)) begin
			check("apb psel", 1, 32'(psel));
			check("apb ready while busy", 0, 32'(ready));
			check("apb paddr", 32'(apb_addr), 32'(paddr));
			check("apb pwrite", 32'(apb_write), 32'(pwrite));
			check("apb pstrb", 32'(apb_strb), 32'(pstrb));
			check("apb pwdata", apb_wdata, pwdata & apb_mask);
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > CYCLES_PER_INST * issued + CYCLE_SLACK) begin
			$display("timeout after %0d cycles, %0d expected results never arrived",
				cycles, exp_name_q.size());
			$display("sim failed");
			$finish;
		end
	end

	initial begin
		logic [5:0]  opc;
		logic [31:0] b;
		logic [31:0] eff;
		logic [15:0] imm;
		int          count_before;
		void'($urandom(33226));
		reset      = 1'b1;
		flush      = 1'b0;
		valid      = 1'b0;
		inst       = '0;
		base       = '0;
		store_data = '0;
		for (int i = 0; i < WORDS; i++) begin
			shadow[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, i[7:0] + 8'd1};
		end
		repeat (5) @(negedge clk);
		reset = 1'b0;
		check("reset ready", 1, 32'(ready));
		check("reset psel", 0, 32'(psel));
		check("reset penable", 0, 32'(penable));
		check("reset wb_valid", 0, 32'(wb_valid));
		check("reset err", 0, 32'(err));
		check("reset wb_wren", 0, 32'(wb_wren));
		finish_test("reset");

		issue("sw word", lsu_pkg::OPC_SW, 5'd1, 32'h40, 16'h0, 32'h11223344, 1'b0);
		issue("lw after sw", lsu_pkg::OPC_LW, 5'd2, 32'h40, 16'h0, '0, 1'b0);
		issue("sb byte 1", lsu_pkg::OPC_SB, 5'd1, 32'h40, 16'h1, 32'h000000ab, 1'b0);
		issue("lw after sb", lsu_pkg::OPC_LW, 5'd3, 32'h40, 16'h0, '0, 1'b0);
		issue("sh half 1", lsu_pkg::OPC_SH, 5'd1, 32'h42, 16'h0, 32'h0000beef, 1'b0);
		issue("lw after sh", lsu_pkg::OPC_LW, 5'd4, 32'h3c, 16'h4, '0, 1'b0);
		finish_test("store widths");

		// bytes 01 7f ff 80 and halves 7f01 80ff cover both extensions
		issue("sw bytes", lsu_pkg::OPC_SW, 5'd1, 32'h80, 16'h0, 32'h80ff7f01, 1'b0);
		for (int k = 0; k < 4; k++) begin
			issue($sformatf("lb off %0d", k), lsu_pkg::OPC_LB, 5'(4 + k), 32'h80 + k,
				16'h0, '0, 1'b0);
			issue($sformatf("lbu off %0d", k), lsu_pkg::OPC_LBU, 5'(8 + k), 32'h80 + k,
				16'h0, '0, 1'b0);
			if (k % 2 == 0) begin
				issue($sformatf("lh off %0d", k), lsu_pkg::OPC_LH, 5'(12 + k), 32'h80 + k,
					16'h0, '0, 1'b0);
				issue($sformatf("lhu off %0d", k), lsu_pkg::OPC_LHU, 5'(16 + k), 32'h80 + k,
					16'h0, '0, 1'b0);
			end
		end
		finish_test("byte and half loads");

		issue("sw partial", lsu_pkg::OPC_SW, 5'd1, 32'h100, 16'h0, 32'hc0d1e2f3, 1'b0);
		for (int k = 0; k < 4; k++) begin
			issue($sformatf("lwl off %0d", k), lsu_pkg::OPC_LWL, 5'(20 + k), 32'h104 + k,
				16'hfffc, '0, 1'b0);
			issue($sformatf("lwr off %0d", k), lsu_pkg::OPC_LWR, 5'(24 + k), 32'h104 + k,
				16'hfffc, '0, 1'b0);
		end
		finish_test("lwl and lwr");

		count_before = xfer_count;
		issue("lh odd", lsu_pkg::OPC_LH, 5'd5, 32'h81, 16'h0, '0, 1'b0);
		issue("lhu odd", lsu_pkg::OPC_LHU, 5'd5, 32'h80, 16'h3, '0, 1'b0);
		issue("lw half aligned", lsu_pkg::OPC_LW, 5'd5, 32'h82, 16'h0, '0, 1'b0);
		issue("sw odd", lsu_pkg::OPC_SW, 5'd5, 32'h41, 16'h0, 32'hdeadbeef, 1'b0);
		drain();
		check("misaligned bus transfers", 32'(count_before), 32'(xfer_count));
		finish_test("misaligned");

		issue("flushed lw", lsu_pkg::OPC_LW, 5'd6, 32'h40, 16'h0, '0, 1'b1);
		flush = 1'b1;
		@(negedge clk);
		flush = 1'b0;
		issue("lw after flush", lsu_pkg::OPC_LW, 5'd7, 32'h100, 16'h0, '0, 1'b0);
		finish_test("flush");

		for (int n = 0; n < RANDOM_OPS; n++) begin
			opc = pick_opcode($urandom % 10);
			b   = $urandom % (4 * WORDS);
			imm = 16'($urandom % 64) - 16'd32;
			eff = b + {{16{imm[15]}}, imm};
			// pull the base back so the access is legal
			if (opc == lsu_pkg::OPC_LH || opc == lsu_pkg::OPC_LHU || opc == lsu_pkg::OPC_SH) begin
				b = b - eff[0];
			end else if (opc == lsu_pkg::OPC_LW || opc == lsu_pkg::OPC_SW) begin
				b = b - eff[1:0];
			end
			issue($sformatf("random %0d", n), opc, 5'($urandom), b, imm, $urandom, 1'b0);
		end
		finish_test("random");

		$display("%0d checks, %0d errors, %0d instructions issued",
			check_count, error_count, issued);
		if (error_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- test/apb_mem_model.sv
`default_nettype none

module apb_mem_model #(
	parameter int ADDR_WIDTH = 10
) (
	input  logic                  clk,
	input  logic                  reset_i,
	input  logic                  psel_i,
	input  logic                  penable_i,
	input  logic                  pwrite_i,
	input  logic [ADDR_WIDTH-1:0] paddr_i,
	input  logic [31:0]           pwdata_i,
	input  logic [3:0]            pstrb_i,
	output logic [31:0]           prdata_o,
	output logic                  pready_o,
	output logic                  pslverr_o,
	output int                    xfer_count_o
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int DEPTH = 2 ** (ADDR_WIDTH - 2);

	logic [31:0]           mem [DEPTH];
	logic [1:0]            wait_q;
	logic [ADDR_WIDTH-3:0] idx;

	assign idx       = paddr_i[ADDR_WIDTH-1:2];
	assign prdata_o  = mem[idx];
	assign pready_o  = (wait_q == 2'd0);
	assign pslverr_o = 1'b0;

	// every byte of the fill word follows from the word index
	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, i[7:0] + 8'd1};
		end
	end

	always @(posedge clk) begin
		if (reset_i) begin
			wait_q       <= 2'd0;
			xfer_count_o <= 0;
		end else if (psel_i && !penable_i) begin
			// the setup phase draws the wait states of the coming access
			wait_q       <= 2'($urandom % 4);
			xfer_count_o <= xfer_count_o + 1;
		end else if (psel_i && penable_i) begin
			if (wait_q != 2'd0) begin
				wait_q <= wait_q - 2'd1;
			end else if (pwrite_i) begin
				for (int b = 0; b < 4; b++) begin
					if (pstrb_i[b]) begin
						mem[idx][8*b +: 8] <= pwdata_i[8*b +: 8];
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/lsu_top.sv
`default_nettype none

module lsu_top #(
	parameter int ADDR_WIDTH = 32
) (
	input  logic                                clk,
	input  logic                                reset_i,
	input  logic                                flush_i,
	input  logic                                valid_i,
	output logic                                ready_o,
	input  logic [31:0]                         inst_i,
	input  logic [lsu_pkg::DATA_WIDTH-1:0]      base_i,
	input  logic [lsu_pkg::DATA_WIDTH-1:0]      store_data_i,
	output logic                                psel_o,
	output logic                                penable_o,
	output logic                                pwrite_o,
	output logic [ADDR_WIDTH-1:0]               paddr_o,
	output logic [lsu_pkg::DATA_WIDTH-1:0]      pwdata_o,
	output logic [lsu_pkg::DATA_WIDTH/8-1:0]    pstrb_o,
	input  logic [lsu_pkg::DATA_WIDTH-1:0]      prdata_i,
	input  logic                                pready_i,
	input  logic                                pslverr_i,
	output logic                                wb_valid_o,
	output logic [lsu_pkg::REG_ADDR_WIDTH-1:0]  wb_waddr_o,
	output logic [lsu_pkg::DATA_WIDTH-1:0]      wb_wdata_o,
	output logic [3:0]                          wb_wren_o,
	output logic                                err_o
);

	lsu_pkg::mem_op_e                   mem_op;
	logic [lsu_pkg::REG_ADDR_WIDTH-1:0] dest_reg;
	logic [15:0]                        offset;

	logic                               xfer_done;
	lsu_pkg::mem_op_e                   xfer_op;
	logic [lsu_pkg::REG_ADDR_WIDTH-1:0] xfer_dest;
	logic [1:0]                         xfer_addr_low;
	logic [lsu_pkg::DATA_WIDTH-1:0]     xfer_rdata;
	logic                               xfer_err;

	lsu_decode lsu_decode_i (
		.inst_i     (inst_i),
		.mem_op_o   (mem_op),
		.dest_reg_o (dest_reg),
		.offset_o   (offset)
	);

	lsu_execute #(
		.ADDR_WIDTH (ADDR_WIDTH)
	) lsu_execute_i (
		.clk             (clk),
		.reset_i         (reset_i),
		.valid_i         (valid_i),
		.ready_o         (ready_o),
		.flush_i         (flush_i),
		.mem_op_i        (mem_op),
		.dest_reg_i      (dest_reg),
		.offset_i        (offset),
		.base_i          (base_i),
		.store_data_i    (store_data_i),
		.psel_o          (psel_o),
		.penable_o       (penable_o),
		.pwrite_o        (pwrite_o),
		.paddr_o         (paddr_o),
		.pwdata_o        (pwdata_o),
		.pstrb_o         (pstrb_o),
		.prdata_i        (prdata_i),
		.pready_i        (pready_i),
		.pslverr_i       (pslverr_i),
		.xfer_done_o     (xfer_done),
		.xfer_op_o       (xfer_op),
		.xfer_dest_o     (xfer_dest),
		.xfer_addr_low_o (xfer_addr_low),
		.xfer_rdata_o    (xfer_rdata),
		.xfer_err_o      (xfer_err)
	);

	lsu_result lsu_result_i (
		.clk             (clk),
		.reset_i         (reset_i),
		.flush_i         (flush_i),
		.xfer_done_i     (xfer_done),
		.xfer_op_i       (xfer_op),
		.xfer_dest_i     (xfer_dest),
		.xfer_addr_low_i (xfer_addr_low),
		.xfer_rdata_i    (xfer_rdata),
		.xfer_err_i      (xfer_err),
		.wb_valid_o      (wb_valid_o),
		.wb_waddr_o      (wb_waddr_o),
		.wb_wdata_o      (wb_wdata_o),
		.wb_wren_o       (wb_wren_o),
		.err_o           (err_o)
	);

endmodule

`default_nettype wire

//--- hw/lsu_result.sv
`default_nettype none

module lsu_result (
	input  logic                                clk,
	input  logic                                reset_i,
	input  logic                                flush_i,
	input  logic                                xfer_done_i,
	input  lsu_pkg::mem_op_e                    xfer_op_i,
	input  logic [lsu_pkg::REG_ADDR_WIDTH-1:0]  xfer_dest_i,
	input  logic [1:0]                          xfer_addr_low_i,
	input  logic [lsu_pkg::DATA_WIDTH-1:0]      xfer_rdata_i,
	input  logic                                xfer_err_i,
	output logic                                wb_valid_o,
	output logic [lsu_pkg::REG_ADDR_WIDTH-1:0]  wb_waddr_o,
	output logic [lsu_pkg::DATA_WIDTH-1:0]      wb_wdata_o,
	output logic [3:0]                          wb_wren_o,
	output logic                                err_o
);

	localparam int DW = lsu_pkg::DATA_WIDTH;

	logic          is_load;
	logic          wb_load;
	logic [7:0]    sel_byte;
	logic [15:0]   sel_half;
	logic [DW-1:0] load_data;
	logic [3:0]    load_wren;

	// loads sit below the stores in the operation encoding
	assign is_load = (xfer_op_i != lsu_pkg::OP_NONE) && (xfer_op_i <= lsu_pkg::LWR);
	assign wb_load = xfer_done_i & is_load & ~xfer_err_i;

	assign sel_byte = xfer_rdata_i[8 * xfer_addr_low_i +: 8];
	assign sel_half = xfer_addr_low_i[1] ? xfer_rdata_i[31:16] : xfer_rdata_i[15:0];

	always_comb begin
		load_data = xfer_rdata_i;
		load_wren = 4'b1111;
		case (xfer_op_i)
			lsu_pkg::LB: begin
				load_data = {{24{sel_byte[7]}}, sel_byte};
			end
			lsu_pkg::LBU: begin
				load_data = {24'b0, sel_byte};
			end
			lsu_pkg::LH: begin
				load_data = {{16{sel_half[15]}}, sel_half};
			end
			lsu_pkg::LHU: begin
				load_data = {16'b0, sel_half};
			end
			lsu_pkg::LWL: begin
				// low bytes of the word move up into the register top
				case (xfer_addr_low_i)
					2'd0: begin
						load_data = {xfer_rdata_i[7:0], 24'b0};
						load_wren = 4'b1000;
					end
					2'd1: begin
						load_data = {xfer_rdata_i[15:0], 16'b0};
						load_wren = 4'b1100;
					end
					2'd2: begin
						load_data = {xfer_rdata_i[23:0], 8'b0};
						load_wren = 4'b1110;
					end
					default: begin
						load_data = xfer_rdata_i;
						load_wren = 4'b1111;
					end
				endcase
			end
			lsu_pkg::LWR: begin
				// high bytes move down into the register bottom
				case (xfer_addr_low_i)
					2'd0: begin
						load_data = xfer_rdata_i;
						load_wren = 4'b1111;
					end
					2'd1: begin
						load_data = {8'b0, xfer_rdata_i[31:8]};
						load_wren = 4'b0111;
					end
					2'd2: begin
						load_data = {16'b0, xfer_rdata_i[31:16]};
						load_wren = 4'b0011;
					end
					default: begin
						load_data = {24'b0, xfer_rdata_i[31:24]};
						load_wren = 4'b0001;
					end
				endcase
			end
			default: begin
				load_data = xfer_rdata_i;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset_i || flush_i) begin
			wb_valid_o <= 1'b0;
			wb_wren_o  <= 4'b0;
			err_o      <= 1'b0;
		end else begin
			// stores finish here silently, errors only raise err_o
			wb_valid_o <= wb_load;
			wb_wren_o  <= wb_load ? load_wren : 4'b0;
			err_o      <= xfer_done_i & xfer_err_i;
		end
	end

	always_ff @(posedge clk) begin
		if (flush_i) begin
			wb_waddr_o <= '0;
			wb_wdata_o <= '0;
		end else if (xfer_done_i) begin
			wb_waddr_o <= xfer_dest_i;
			wb_wdata_o <= load_data;
		end
	end

endmodule

`default_nettype wire

//--- hw/lsu_execute.sv
`default_nettype none

module lsu_execute #(
	parameter int ADDR_WIDTH = 32
) (
	input  logic                                clk,
	input  logic                                reset_i,
	input  logic                                valid_i,
	output logic                                ready_o,
	input  logic                                flush_i,
	input  lsu_pkg::mem_op_e                    mem_op_i,
	input  logic [lsu_pkg::REG_ADDR_WIDTH-1:0]  dest_reg_i,
	input  logic [15:0]                         offset_i,
	input  logic [lsu_pkg::DATA_WIDTH-1:0]      base_i,
	input  logic [lsu_pkg::DATA_WIDTH-1:0]      store_data_i,
	output logic                                psel_o,
	output logic                                penable_o,
	output logic                                pwrite_o,
	output logic [ADDR_WIDTH-1:0]               paddr_o,
	output logic [lsu_pkg::DATA_WIDTH-1:0]      pwdata_o,
	output logic [lsu_pkg::DATA_WIDTH/8-1:0]    pstrb_o,
	input  logic [lsu_pkg::DATA_WIDTH-1:0]      prdata_i,
	input  logic                                pready_i,
	input  logic                                pslverr_i,
	output logic                                xfer_done_o,
	output lsu_pkg::mem_op_e                    xfer_op_o,
	output logic [lsu_pkg::REG_ADDR_WIDTH-1:0]  xfer_dest_o,
	output logic [1:0]                          xfer_addr_low_o,
	output logic [lsu_pkg::DATA_WIDTH-1:0]      xfer_rdata_o,
	output logic                                xfer_err_o
);

	localparam int DW = lsu_pkg::DATA_WIDTH;
	localparam int SW = lsu_pkg::DATA_WIDTH / 8;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SETUP,
		ST_ACCESS
	} state_e;

	state_e                             state_q;
	logic                               kill_q;
	lsu_pkg::mem_op_e                   op_q;
	logic [lsu_pkg::REG_ADDR_WIDTH-1:0] dest_q;
	logic [ADDR_WIDTH-1:0]              addr_q;
	logic                               write_q;
	logic                               misalign_q;
	logic [DW-1:0]                      wdata_q;
	logic [SW-1:0]                      strb_q;

	logic                               accept;
	logic [DW-1:0]                      eff_addr;
	logic                               misalign;
	logic                               is_store;
	logic [DW-1:0]                      wdata_d;
	logic [SW-1:0]                      strb_d;

	assign ready_o = (state_q == ST_IDLE);
	assign accept  = valid_i & ready_o;

	// base plus sign extended immediate
	assign eff_addr = base_i + {{(DW - 16){offset_i[15]}}, offset_i};

	// alignment check and store lane placement
	always_comb begin
		misalign = 1'b0;
		is_store = 1'b0;
		wdata_d  = store_data_i;
		strb_d   = '0;
		case (mem_op_i)
			lsu_pkg::LH, lsu_pkg::LHU: begin
				misalign = eff_addr[0];
			end
			lsu_pkg::LW: begin
				misalign = |eff_addr[1:0];
			end
			lsu_pkg::SB: begin
				is_store = 1'b1;
				wdata_d  = {4{store_data_i[7:0]}};
				strb_d   = 4'b0001 << eff_addr[1:0];
			end
			lsu_pkg::SH: begin
				is_store = 1'b1;
				misalign = eff_addr[0];
				wdata_d  = {2{store_data_i[15:0]}};
				strb_d   = eff_addr[1] ? 4'b1100 : 4'b0011;
			end
			lsu_pkg::SW: begin
				is_store = 1'b1;
				misalign = |eff_addr[1:0];
				strb_d   = 4'b1111;
			end
			default: begin
				misalign = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			state_q <= ST_IDLE;
			kill_q  <= 1'b0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					// OP_NONE is taken and dropped here
					if (accept && mem_op_i != lsu_pkg::OP_NONE) begin
						state_q <= ST_SETUP;
					end
				end
				ST_SETUP: begin
					state_q <= misalign_q ? ST_IDLE : ST_ACCESS;
				end
				ST_ACCESS: begin
					if (pready_i) begin
						state_q <= ST_IDLE;
					end
				end
				default: begin
					state_q <= ST_IDLE;
				end
			endcase
			// a flush in the accept cycle squashes the new item too
			if (accept) begin
				kill_q <= flush_i;
			end else if (flush_i) begin
				kill_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			op_q       <= mem_op_i;
			dest_q     <= dest_reg_i;
			addr_q     <= eff_addr[ADDR_WIDTH-1:0];
			write_q    <= is_store;
			misalign_q <= misalign;
			wdata_q    <= wdata_d;
			strb_q     <= is_store ? strb_d : '0;
		end
	end

	// misaligned items sit one cycle in setup without selecting the slave
	assign psel_o    = (state_q == ST_SETUP && !misalign_q) || (state_q == ST_ACCESS);
	assign penable_o = (state_q == ST_ACCESS);
	assign pwrite_o  = write_q;
	assign paddr_o   = {addr_q[ADDR_WIDTH-1:2], 2'b00};
	assign pwdata_o  = wdata_q;
	assign pstrb_o   = strb_q;

	assign xfer_done_o = ~kill_q & ((state_q == ST_SETUP && misalign_q) ||
	                                (state_q == ST_ACCESS && pready_i));
	assign xfer_op_o       = op_q;
	assign xfer_dest_o     = dest_q;
	assign xfer_addr_low_o = addr_q[1:0];
	assign xfer_rdata_o    = prdata_i;
	assign xfer_err_o      = misalign_q | pslverr_i;

endmodule

`default_nettype wire

//--- hw/lsu_decode.sv
`default_nettype none

module lsu_decode (
	input  logic [31:0]                         inst_i,
	output lsu_pkg::mem_op_e                    mem_op_o,
	output logic [lsu_pkg::REG_ADDR_WIDTH-1:0]  dest_reg_o,
	output logic [15:0]                         offset_o
);

	logic [5:0] opcode;

	assign opcode = inst_i[31:26];

	// rt is the load destination and also the store data source
	assign dest_reg_o = inst_i[20:16];

	// immediate field, sign extended later in execute
	assign offset_o = inst_i[15:0];

	always_comb begin
		case (opcode)
			lsu_pkg::OPC_LB: begin
				mem_op_o = lsu_pkg::LB;
			end
			lsu_pkg::OPC_LBU: begin
				mem_op_o = lsu_pkg::LBU;
			end
			lsu_pkg::OPC_LH: begin
				mem_op_o = lsu_pkg::LH;
			end
			lsu_pkg::OPC_LHU: begin
				mem_op_o = lsu_pkg::LHU;
			end
			lsu_pkg::OPC_LW: begin
				mem_op_o = lsu_pkg::LW;
			end
			lsu_pkg::OPC_LWL: begin
				mem_op_o = lsu_pkg::LWL;
			end
			lsu_pkg::OPC_LWR: begin
				mem_op_o = lsu_pkg::LWR;
			end
			lsu_pkg::OPC_SB: begin
				mem_op_o = lsu_pkg::SB;
			end
			lsu_pkg::OPC_SH: begin
				mem_op_o = lsu_pkg::SH;
			end
			lsu_pkg::OPC_SW: begin
				mem_op_o = lsu_pkg::SW;
			end
			// anything else is not a memory instruction
			default: begin
				mem_op_o = lsu_pkg::OP_NONE;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- hw/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

	// register and bus data width, one word
	localparam int DATA_WIDTH = 32;

	// register file index width
	localparam int REG_ADDR_WIDTH = 5;

	// primary opcodes of the memory instructions, bits 31:26
	localparam logic [5:0] OPC_LB  = 6'h20;
	localparam logic [5:0] OPC_LH  = 6'h21;
	localparam logic [5:0] OPC_LWL = 6'h22;
	localparam logic [5:0] OPC_LW  = 6'h23;
	localparam logic [5:0] OPC_LBU = 6'h24;
	localparam logic [5:0] OPC_LHU = 6'h25;
	localparam logic [5:0] OPC_LWR = 6'h26;
	localparam logic [5:0] OPC_SB  = 6'h28;
	localparam logic [5:0] OPC_SH  = 6'h29;
	localparam logic [5:0] OPC_SW  = 6'h2B;

	// memory operation carried down the load/store path
	// loads first so a range test separates them from stores
	typedef enum logic [3:0] {
		OP_NONE = 4'd0,
		LB      = 4'd1,
		LBU     = 4'd2,
		LH      = 4'd3,
		LHU     = 4'd4,
		LW      = 4'd5,
		LWL     = 4'd6,
		LWR     = 4'd7,
		SB      = 4'd8,
		SH      = 4'd9,
		SW      = 4'd10
	} mem_op_e;

endpackage

`default_nettype wire
